/* flist.f */
resp_park_pkg.sv
occupancy_counter.sv
slot_ctrl.sv
payload_store.sv
response_park.sv
tb_response_park.sv

/* occupancy_counter.sv */
// Slot occupancy counter
`default_nettype none
`timescale 1ns/1ps

module occupancy_counter (
  input  logic clk,
  input  logic rst,
  input  logic inc,
  input  logic dec,
  output logic full
);

  import resp_park_pkg::*;

  // ==================================================
  // Occupied slot count
  // ==================================================

  // Number of slots that currently hold a parked response
  count_t count_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else if (inc && !dec) begin
      // A new response was accepted this cycle
      count_q <= count_q + count_t'(1);
    end else if (dec && !inc && (count_q != '0)) begin
      // An occupied slot was released
      // The zero check keeps the count from wrapping below empty
      count_q <= count_q - count_t'(1);
    end
    // Accept and release together leave the count where it is
  end

  // ==================================================
  // Headroom threshold
  // ==================================================

  // Full comes from the registered count only, so it settles early in the
  // cycle and can feed the enqueue ready without a long path
  // It asserts one slot before the store is physically full
  assign full = (count_q == count_t'(CAP_THRESHOLD));

endmodule

`default_nettype wire

/* payload_store.sv */
// Response payload store
`default_nettype none
`timescale 1ns/1ps

module payload_store (
  input  logic                 clk,
  input  logic                 rst,
  // Write port, one slot per accepted beat
  input  logic                 write_en,
  input  resp_park_pkg::uid_t  write_uid,
  input  resp_park_pkg::data_t in_data,
  input  resp_park_pkg::resp_t in_resp,
  input  resp_park_pkg::rid_t  in_rid,
  input  resp_park_pkg::tag_t  in_tag,
  // Grant copy-out
  input  logic                 grant_now,
  input  resp_park_pkg::uid_t  grant_uid,
  output resp_park_pkg::data_t out_data,
  output resp_park_pkg::resp_t out_resp,
  output resp_park_pkg::rid_t  out_rid,
  output resp_park_pkg::tag_t  out_tag
);

  import resp_park_pkg::*;

  // ==================================================
  // Slot payload memory
  // ==================================================

  // The four response fields, one entry per UID
  data_t data_mem [SLOT_COUNT];
  resp_t resp_mem [SLOT_COUNT];
  rid_t  rid_mem  [SLOT_COUNT];
  tag_t  tag_mem  [SLOT_COUNT];

  // Only an accepted beat writes, and it always lands in an empty slot
  always_ff @(posedge clk) begin
    if (write_en) begin
      data_mem[write_uid] <= in_data;
      resp_mem[write_uid] <= in_resp;
      rid_mem[write_uid] <= in_rid;
      tag_mem[write_uid] <= in_tag;
    end
  end

  // ==================================================
  // Output copy
  // ==================================================

  // The copy is taken from the pre-edge contents, one cycle after the grant
  // It appears in the same cycle as out_valid from the controller
  always_ff @(posedge clk) begin
    if (rst) begin
      out_data <= '0;
      out_resp <= '0;
      out_rid <= '0;
      out_tag <= '0;
    end else if (grant_now) begin
      out_data <= data_mem[grant_uid];
      out_resp <= resp_mem[grant_uid];
      out_rid <= rid_mem[grant_uid];
      out_tag <= tag_mem[grant_uid];
    end else begin
      // Outside a grant the bus reads zero
      out_data <= '0;
      out_resp <= '0;
      out_rid <= '0;
      out_tag <= '0;
    end
  end

endmodule

`default_nettype wire

/* resp_park_pkg.sv */
// Response park shared definitions
`default_nettype none

package resp_park_pkg;

  // ==================================================
  // UID space and capacity
  // ==================================================

  // The UID is a row field above a column field
  localparam int NUM_ROWS = 4;
  localparam int NUM_COLS = 4;
  localparam int UID_W = $clog2(NUM_ROWS) + $clog2(NUM_COLS);

  // One slot per UID
  localparam int SLOT_COUNT = NUM_ROWS * NUM_COLS;

  // Slots held back across the fabric to avoid deadlock
  localparam int HEADROOM = 1;

  // Full is reported at this occupancy, one slot before the real limit
  localparam int CAP_THRESHOLD = SLOT_COUNT - HEADROOM;

  // Wide enough to hold SLOT_COUNT itself
  localparam int COUNT_W = $clog2(SLOT_COUNT) + 1;

  // ==================================================
  // Payload field widths
  // ==================================================

  localparam int DATA_W = 32;
  localparam int RESP_W = 2;
  localparam int RID_W = 4;
  localparam int TAG_W = 4;

  // ==================================================
  // Vector types
  // ==================================================

  typedef logic [UID_W-1:0]   uid_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [RESP_W-1:0]  resp_t;
  // Original read ID, returned to the requester untouched
  typedef logic [RID_W-1:0]   rid_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [COUNT_W-1:0] count_t;

endpackage

`default_nettype wire

/* response_park.sv */
// Response parking store top level
`default_nettype none
`timescale 1ns/1ps

module response_park (
  input  logic                 clk,
  input  logic                 rst,
  // ==================================================
  // Enqueue from the producer
  // ==================================================
  input  logic                 in_valid,
  output logic                 in_ready,
  input  resp_park_pkg::uid_t  in_uid,
  input  resp_park_pkg::data_t in_data,
  input  resp_park_pkg::resp_t in_resp,
  input  resp_park_pkg::rid_t  in_rid,
  input  resp_park_pkg::tag_t  in_tag,
  // Allocate from the arbiter
  input  logic                 alloc_req,
  input  resp_park_pkg::uid_t  alloc_uid,
  // Free from the consumer
  input  logic                 free_req,
  input  resp_park_pkg::uid_t  free_uid,
  // ==================================================
  // Output to the consumer, no back-pressure
  // ==================================================
  output logic                 out_valid,
  output resp_park_pkg::data_t out_data,
  output resp_park_pkg::resp_t out_resp,
  output resp_park_pkg::rid_t  out_rid,
  output resp_park_pkg::tag_t  out_tag,
  output logic                 free_ack,
  output logic                 full
);

  import resp_park_pkg::*;

  // Store controls from the flag controller
  logic write_en;
  uid_t write_uid;
  logic grant_now;
  uid_t grant_uid;

  // Counter controls
  logic inc;
  logic dec;

  // Flags, handshake decisions and the output pulses
  slot_ctrl slot_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_uid    (in_uid),
    .in_ready  (in_ready),
    .alloc_req (alloc_req),
    .alloc_uid (alloc_uid),
    .free_req  (free_req),
    .free_uid  (free_uid),
    .full      (full),
    .write_en  (write_en),
    .write_uid (write_uid),
    .grant_now (grant_now),
    .grant_uid (grant_uid),
    .inc       (inc),
    .dec       (dec),
    .out_valid (out_valid),
    .free_ack  (free_ack)
  );

  // Occupancy with the headroom full flag, which also throttles enqueue
  occupancy_counter occupancy_counter_inst (
    .clk  (clk),
    .rst  (rst),
    .inc  (inc),
    .dec  (dec),
    .full (full)
  );

  // Payload slots and the registered copy-out
  payload_store payload_store_inst (
    .clk       (clk),
    .rst       (rst),
    .write_en  (write_en),
    .write_uid (write_uid),
    .in_data   (in_data),
    .in_resp   (in_resp),
    .in_rid    (in_rid),
    .in_tag    (in_tag),
    .grant_now (grant_now),
    .grant_uid (grant_uid),
    .out_data  (out_data),
    .out_resp  (out_resp),
    .out_rid   (out_rid),
    .out_tag   (out_tag)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the response park testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_response_park -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_response_park > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "No pass message found in $LOG"
  exit 1
fi
exit 0

/* slot_ctrl.sv */
// Slot flag controller
`default_nettype none
`timescale 1ns/1ps

module slot_ctrl (
  input  logic                clk,
  input  logic                rst,
  // Enqueue side
  input  logic                in_valid,
  input  resp_park_pkg::uid_t in_uid,
  output logic                in_ready,
  // Allocate request from the arbiter
  input  logic                alloc_req,
  input  resp_park_pkg::uid_t alloc_uid,
  // Free request from the consumer
  input  logic                free_req,
  input  resp_park_pkg::uid_t free_uid,
  // Headroom flag from the counter
  input  logic                full,
  // Payload store controls
  output logic                write_en,
  output resp_park_pkg::uid_t write_uid,
  output logic                grant_now,
  output resp_park_pkg::uid_t grant_uid,
  // Occupancy counter controls
  output logic                inc,
  output logic                dec,
  // Registered pulses
  output logic                out_valid,
  output logic                free_ack
);

  import resp_park_pkg::*;

  // ==================================================
  // Per-slot flags
  // ==================================================

  // Occupied means the slot holds a parked response
  logic [SLOT_COUNT-1:0] occupied_q;
  logic [SLOT_COUNT-1:0] occupied_d;
  // Reserved means the payload was handed out and waits for a free
  logic [SLOT_COUNT-1:0] reserved_q;
  logic [SLOT_COUNT-1:0] reserved_d;

  // Accept and release events of this cycle
  logic accept_now;
  logic release_now;

  // ==================================================
  // Decisions from the pre-edge flags
  // ==================================================

  // Back-pressure when the headroom threshold is reached or the slot is taken
  assign in_ready = !full && !occupied_q[in_uid];
  assign accept_now = in_valid && in_ready;

  // A slot is granted once, and only while it holds a response
  assign grant_now = alloc_req && occupied_q[alloc_uid] && !reserved_q[alloc_uid];

  // Freeing an empty slot does nothing
  assign release_now = free_req && occupied_q[free_uid];

  // The store writes at the handshake and copies out on grant
  assign write_en = accept_now;
  assign write_uid = in_uid;
  assign grant_uid = alloc_uid;

  // Each accepted beat fills exactly one slot and each release empties one
  assign inc = accept_now;
  assign dec = release_now;

  // ==================================================
  // Next flag state
  // ==================================================

  always_comb begin
    occupied_d = occupied_q;
    reserved_d = reserved_q;
    // A fresh response is parked and not yet handed out
    if (accept_now) begin
      occupied_d[in_uid] = 1'b1;
      reserved_d[in_uid] = 1'b0;
    end
    if (grant_now) begin
      reserved_d[alloc_uid] = 1'b1;
    end
    // Release goes last, so a grant and a free of one slot in the same
    // cycle still hands out the payload and then empties the slot
    if (release_now) begin
      occupied_d[free_uid] = 1'b0;
      reserved_d[free_uid] = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      occupied_q <= '0;
      reserved_q <= '0;
      out_valid <= 1'b0;
      free_ack <= 1'b0;
    end else begin
      occupied_q <= occupied_d;
      reserved_q <= reserved_d;
      // Both pulses last one cycle and line up with the registered payload
      out_valid <= grant_now;
      free_ack <= release_now;
    end
  end

endmodule

`default_nettype wire

/* tb_response_park.sv */
// Response park testbench
`default_nettype none
`timescale 1ns/1ps

module tb_response_park;

  import resp_park_pkg::*;

  // The tests take a few hundred cycles, so this leaves a wide margin
  localparam int WATCHDOG_CYCLES = 4000;
  localparam logic [15:0] LFSR_SEED = 16'd49461;
  // Data, response code, original ID and tag side by side
  localparam int PAYLOAD_W = DATA_W + RESP_W + RID_W + TAG_W;

  logic  clk;
  logic  rst;
  logic  in_valid;
  logic  in_ready;
  uid_t  in_uid;
  data_t in_data;
  resp_t in_resp;
  rid_t  in_rid;
  tag_t  in_tag;
  logic  alloc_req;
  uid_t  alloc_uid;
  logic  free_req;
  uid_t  free_uid;
  logic  out_valid;
  data_t out_data;
  resp_t out_resp;
  rid_t  out_rid;
  tag_t  out_tag;
  logic  free_ack;
  logic  full;

  // Stimulus staged by the tests and applied on the next falling edge
  logic                 nxt_in_valid;
  uid_t                 nxt_in_uid;
  logic [PAYLOAD_W-1:0] nxt_payload;
  logic                 nxt_alloc_req;
  uid_t                 nxt_alloc_uid;
  logic                 nxt_free_req;
  uid_t                 nxt_free_uid;

  // ==================================================
  // Scoreboard model
  // ==================================================

  logic [SLOT_COUNT-1:0] m_occ;
  logic [SLOT_COUNT-1:0] m_res;
  int                    m_cnt;
  logic [PAYLOAD_W-1:0]  m_payload [SLOT_COUNT];
  // Results of the coming edge, visible on the outputs one cycle later
  logic                 pend_valid;
  logic                 pend_ack;
  logic [PAYLOAD_W-1:0] pend_payload;
  // Expected values, sampled by the assertions at the rising edge
  logic                 exp_ready;
  logic                 exp_full;
  logic                 exp_valid;
  logic                 exp_ack;
  logic [PAYLOAD_W-1:0] exp_payload;
  logic [15:0]          lfsr_q;
  string                test_name;
  int                   value_errors = 0;
  int                   other_errors = 0;

  response_park response_park_inst (
    .clk (clk), .rst (rst),
    .in_valid (in_valid), .in_ready (in_ready), .in_uid (in_uid),
    .in_data (in_data), .in_resp (in_resp), .in_rid (in_rid), .in_tag (in_tag),
    .alloc_req (alloc_req), .alloc_uid (alloc_uid),
    .free_req (free_req), .free_uid (free_uid),
    .out_valid (out_valid), .out_data (out_data), .out_resp (out_resp),
    .out_rid (out_rid), .out_tag (out_tag), .free_ack (free_ack), .full (full)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step for every payload bit
  task automatic random_payload(output logic [PAYLOAD_W-1:0] p);
    for (int i = 0; i < PAYLOAD_W; i++) begin
      p[i] = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  function automatic void report_mismatch(input string what, input logic [63:0] expected,
                                          input logic [63:0] actual);
    value_errors++;
    $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
  endfunction

  // ==================================================
  // One clock cycle of stimulus and model update
  // ==================================================

  task automatic clock_cycle();
    logic acc;
    logic gnt;
    logic rel;
    @(negedge clk);
    // The outputs now show what the last edge registered
    exp_valid = pend_valid;
    exp_ack = pend_ack;
    exp_payload = pend_payload;
    in_valid = nxt_in_valid;
    in_uid = nxt_in_uid;
    {in_data, in_resp, in_rid, in_tag} = nxt_payload;
    alloc_req = nxt_alloc_req;
    alloc_uid = nxt_alloc_uid;
    free_req = nxt_free_req;
    free_uid = nxt_free_uid;
    // Every decision uses the flags and count from before the coming edge
    exp_full = (m_cnt == CAP_THRESHOLD);
    exp_ready = !exp_full && !m_occ[nxt_in_uid];
    acc = nxt_in_valid && exp_ready;
    gnt = nxt_alloc_req && m_occ[nxt_alloc_uid] && !m_res[nxt_alloc_uid];
    rel = nxt_free_req && m_occ[nxt_free_uid];
    pend_valid = gnt;
    pend_ack = rel;
    pend_payload = gnt ? m_payload[nxt_alloc_uid] : '0;
    if (acc) begin
      m_occ[nxt_in_uid] = 1'b1;
      m_res[nxt_in_uid] = 1'b0;
      m_payload[nxt_in_uid] = nxt_payload;
    end
    if (gnt) begin
      m_res[nxt_alloc_uid] = 1'b1;
    end
    // A free wins over a grant of the same slot
    if (rel) begin
      m_occ[nxt_free_uid] = 1'b0;
      m_res[nxt_free_uid] = 1'b0;
    end
    m_cnt = m_cnt + int'(acc) - int'(rel);
  endtask

  task automatic idle(input int cycles);
    nxt_in_valid = 1'b0;
    nxt_alloc_req = 1'b0;
    nxt_free_req = 1'b0;
    repeat (cycles) clock_cycle();
  endtask

  // Holds a random beat until the handshake or until max_wait cycles pass
  task automatic enqueue_beat(input uid_t uid, input int max_wait, input logic want);
    int waited;
    logic took;
    random_payload(nxt_payload);
    nxt_in_valid = 1'b1;
    nxt_in_uid = uid;
    waited = 0;
    took = 1'b0;
    while (!took && waited < max_wait) begin
      clock_cycle();
      // The DUT handshake is read once its ready has settled on the new inputs
      #1;
      took = in_valid && in_ready;
      waited++;
    end
    nxt_in_valid = 1'b0;
    if (took != want) begin
      other_errors++;
      $display("Error in %s: enqueue to UID %0d was %s", test_name, uid,
               took ? "accepted while it should wait" : "never accepted");
    end
  endtask

  task automatic request_alloc(input uid_t uid);
    nxt_alloc_req = 1'b1;
    nxt_alloc_uid = uid;
    clock_cycle();
    nxt_alloc_req = 1'b0;
  endtask

  task automatic request_free(input uid_t uid);
    nxt_free_req = 1'b1;
    nxt_free_uid = uid;
    clock_cycle();
    nxt_free_req = 1'b0;
  endtask

  task automatic alloc_and_free(input uid_t uid);
    nxt_alloc_req = 1'b1;
    nxt_alloc_uid = uid;
    nxt_free_req = 1'b1;
    nxt_free_uid = uid;
    clock_cycle();
    nxt_alloc_req = 1'b0;
    nxt_free_req = 1'b0;
  endtask

  // ==================================================
  // Checks against the model
  // ==================================================

  ready_check: assert property (@(posedge clk) disable iff (rst) in_ready == exp_ready)
    else report_mismatch("in_ready", 64'(exp_ready), 64'($sampled(in_ready)));
  full_check: assert property (@(posedge clk) disable iff (rst) full == exp_full)
    else report_mismatch("full", 64'(exp_full), 64'($sampled(full)));
  valid_check: assert property (@(posedge clk) disable iff (rst) out_valid == exp_valid)
    else report_mismatch("out_valid", 64'(exp_valid), 64'($sampled(out_valid)));
  ack_check: assert property (@(posedge clk) disable iff (rst) free_ack == exp_ack)
    else report_mismatch("free_ack", 64'(exp_ack), 64'($sampled(free_ack)));
  // Outside out_valid the payload must read zero
  payload_check: assert property (@(posedge clk) disable iff (rst)
                                  {out_data, out_resp, out_rid, out_tag} == exp_payload)
    else report_mismatch("payload", 64'(exp_payload),
                         64'($sampled({out_data, out_resp, out_rid, out_tag})));

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_uid = '0;
    {in_data, in_resp, in_rid, in_tag} = '0;
    alloc_req = 1'b0;
    alloc_uid = '0;
    free_req = 1'b0;
    free_uid = '0;
    nxt_in_valid = 1'b0;
    nxt_in_uid = '0;
    nxt_payload = '0;
    nxt_alloc_req = 1'b0;
    nxt_alloc_uid = '0;
    nxt_free_req = 1'b0;
    nxt_free_uid = '0;
    m_occ = '0;
    m_res = '0;
    m_cnt = 0;
    pend_valid = 1'b0;
    pend_ack = 1'b0;
    pend_payload = '0;
    // Values right after reset
    exp_ready = 1'b1;
    exp_full = 1'b0;
    exp_valid = 1'b0;
    exp_ack = 1'b0;
    exp_payload = '0;
    lfsr_q = LFSR_SEED;
    test_name = "reset";
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idle(3);

    test_name = "round_trip";
    for (int u = 1; u < 4; u++) begin
      enqueue_beat(uid_t'(u * 5), 4, 1'b1);
      request_alloc(uid_t'(u * 5));
      idle(2);
      request_free(uid_t'(u * 5));
      idle(1);
    end

    test_name = "held_slot";
    enqueue_beat(4'd6, 4, 1'b1);
    // The second beat is held and must not overwrite the parked one
    enqueue_beat(4'd6, 5, 1'b0);
    request_alloc(4'd6);
    idle(1);
    request_alloc(4'd6);
    request_alloc(4'd9);
    idle(2);
    request_free(4'd6);
    idle(2);

    test_name = "capacity";
    for (int u = 0; u < CAP_THRESHOLD; u++) begin
      enqueue_beat(uid_t'(u), 4, 1'b1);
    end
    idle(1);
    // Headroom blocks the last empty UID
    enqueue_beat(uid_t'(SLOT_COUNT - 1), 4, 1'b0);
    request_free(4'd3);
    enqueue_beat(uid_t'(SLOT_COUNT - 1), 4, 1'b1);
    idle(2);
    for (int u = 0; u < SLOT_COUNT; u++) begin
      request_free(uid_t'(u));
    end
    idle(2);

    test_name = "release";
    enqueue_beat(4'd7, 4, 1'b1);
    request_free(4'd7);
    idle(1);
    request_alloc(4'd7);
    enqueue_beat(4'd7, 4, 1'b1);
    // UID 12 holds nothing, so no acknowledge is due
    request_free(4'd12);
    idle(1);
    alloc_and_free(4'd7);
    idle(3);

    $display("Error counts: %0d value mismatches, %0d other errors", value_errors,
             other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
